// File: verilog/camera_config_pkg.sv
`default_nettype none

package camera_config_pkg;

	//////////////////////////////////////////////////
	// SCCB bus constants
	//////////////////////////////////////////////////
	localparam logic [7:0] sccb_dev_id = 8'h42; // OV7670 write address

	// Setup table geometry
	localparam int rom_depth  = 30; // Register/value pairs sent
	localparam int rom_addr_w = 6;

	// Writer phases, one per bus condition
	typedef enum logic [1:0] {
		ph_idle,  // Bus released, ready for a request
		ph_start, // Start condition, two quarters
		ph_bit,   // 27 bit slots, four quarters each
		ph_stop   // Stop condition, two quarters
	} sccb_phase_t;

endpackage

`default_nettype wire

// File: verilog/sccb_write_if.sv
`timescale 1ns/1ns
`default_nettype none

// One register write, sequencer to SCCB writer
interface sccb_write_if;
	logic       valid;    // Request held until accepted
	logic       ready;    // Writer idle
	logic [7:0] reg_addr; // Camera sub-address
	logic [7:0] reg_data; // Value for that register

	modport source (
		output valid, reg_addr, reg_data,
		input  ready
	);

	modport sink (
		input  valid, reg_addr, reg_data,
		output ready
	);
endinterface

`default_nettype wire

// File: verilog/camera_setup_rom.sv
`timescale 1ns/1ns
`default_nettype none

module camera_setup_rom (
	input  wire logic                                 clk,
	input  wire logic [camera_config_pkg::rom_addr_w-1:0] rom_addr,
	output logic      [7:0]                           reg_addr,
	output logic      [7:0]                           reg_data
);
	import camera_config_pkg::*;

	// CLKRC at its reset value, harmless to rewrite
	localparam logic [15:0] safe_pair = {8'h11, 8'h80};

	//////////////////////////////////////////////////
	// Register table, one clock of read latency
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rom_addr >= rom_addr_w'(rom_depth)) begin
			{reg_addr, reg_data} <= safe_pair; // Past the end of the table
		end else begin
			case (rom_addr)
				0:  {reg_addr, reg_data} <= {8'h12, 8'h04}; // COM7, RGB output
				1:  {reg_addr, reg_data} <= {8'h11, 8'h80}; // CLKRC prescaler
				2:  {reg_addr, reg_data} <= {8'h40, 8'hd0}; // COM15, RGB565
				3:  {reg_addr, reg_data} <= {8'h1e, 8'h30}; // MVFP, mirror and flip

				// Colour matrix coefficients
				4:  {reg_addr, reg_data} <= {8'h4f, 8'hb3};
				5:  {reg_addr, reg_data} <= {8'h50, 8'hb3};
				6:  {reg_addr, reg_data} <= {8'h51, 8'h00};
				7:  {reg_addr, reg_data} <= {8'h52, 8'h3d};
				8:  {reg_addr, reg_data} <= {8'h53, 8'ha7};
				9:  {reg_addr, reg_data} <= {8'h54, 8'he4};
				10: {reg_addr, reg_data} <= {8'h56, 8'h40}; // Contrast
				11: {reg_addr, reg_data} <= {8'h58, 8'h9e}; // Matrix sign

				// White balance tuning
				12: {reg_addr, reg_data} <= {8'h59, 8'h88};
				13: {reg_addr, reg_data} <= {8'h5a, 8'h88};
				14: {reg_addr, reg_data} <= {8'h5b, 8'h44};
				15: {reg_addr, reg_data} <= {8'h5c, 8'h67};
				16: {reg_addr, reg_data} <= {8'h5d, 8'h49};
				17: {reg_addr, reg_data} <= {8'h5e, 8'h0e};
				18: {reg_addr, reg_data} <= {8'h69, 8'h00}; // Fixed gain
				19: {reg_addr, reg_data} <= {8'h6a, 8'h40}; // G channel gain
				20: {reg_addr, reg_data} <= {8'h6b, 8'h0a}; // PLL off, regulator on
				21: {reg_addr, reg_data} <= {8'h6c, 8'h0a};
				22: {reg_addr, reg_data} <= {8'h6d, 8'h55};
				23: {reg_addr, reg_data} <= {8'h6e, 8'h11};
				24: {reg_addr, reg_data} <= {8'h6f, 8'h9f}; // AWB control

				// Undocumented tuning block
				25: {reg_addr, reg_data} <= {8'hb0, 8'h84};
				26: {reg_addr, reg_data} <= {8'hb1, 8'h0c};
				27: {reg_addr, reg_data} <= {8'hb2, 8'h0e};
				28: {reg_addr, reg_data} <= {8'hb3, 8'h82};
				29: {reg_addr, reg_data} <= {8'hb4, 8'h0a};
				default: {reg_addr, reg_data} <= safe_pair;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/config_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module config_sequencer #(
	parameter int num_entries = camera_config_pkg::rom_depth
) (
	input  wire logic                                 clk,
	input  wire logic                                 arst_n,
	input  wire logic                                 start,
	output logic      [camera_config_pkg::rom_addr_w-1:0] rom_addr,
	input  wire logic [7:0]                           reg_addr,
	input  wire logic [7:0]                           reg_data,
	sccb_write_if.source                              wr,
	output logic                                      busy,
	output logic                                      done
);
	import camera_config_pkg::*;

	localparam logic [rom_addr_w-1:0] last_addr = rom_addr_w'(num_entries - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,   // ROM read in flight
		st_offer,   // Pair on the bus, waiting for ready
		st_drain,   // Last write still on the wire
		st_finished
	} seq_state_t;

	seq_state_t state;
	logic       valid_q;

	// ROM output stays put until the address moves after acceptance
	assign wr.valid    = valid_q;
	assign wr.reg_addr = reg_addr;
	assign wr.reg_data = reg_data;

	//////////////////////////////////////////////////
	// Table walk
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			rom_addr <= '0;
			valid_q  <= 1'b0;
			busy     <= 1'b0;
			done     <= 1'b0;
		end else begin
			case (state)
				st_idle, st_finished: begin
					if (start) begin // Ignored anywhere else
						busy     <= 1'b1;
						done     <= 1'b0;
						rom_addr <= '0;
						state    <= st_fetch;
					end
				end
				st_fetch: begin
					valid_q <= 1'b1; // Data lands this edge
					state   <= st_offer;
				end
				st_offer: begin
					if (wr.ready) begin // Accepted
						valid_q  <= 1'b0;
						rom_addr <= rom_addr + 1'b1;
						state    <= (rom_addr == last_addr) ? st_drain : st_fetch;
					end
				end
				st_drain: begin
					// Ready back high once the stop condition is out
					if (wr.ready) begin
						busy  <= 1'b0;
						done  <= 1'b1;
						state <= st_finished;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/sccb_writer.sv
`timescale 1ns/1ns
`default_nettype none

module sccb_writer #(
	parameter int clk_div = 4 // clk cycles per quarter bit
) (
	input  wire logic clk,
	input  wire logic arst_n,
	sccb_write_if.sink wr,
	output logic      sioc,
	output logic      siod_out,
	output logic      siod_oe
);
	import camera_config_pkg::*;

	localparam int qw = (clk_div > 1) ? $clog2(clk_div) : 1;

	sccb_phase_t phase;
	sccb_phase_t phase_nxt;
	logic [qw-1:0] q_cnt;     // Quarter divider
	logic [qw-1:0] q_nxt;
	logic [1:0]    qtr;       // Quarter within the phase or bit
	logic [1:0]    qtr_nxt;
	logic [4:0]    bit_cnt;   // Slot 0 to 26
	logic [4:0]    bit_nxt;
	logic [26:0]   shift_q;   // MSB goes out first
	logic [26:0]   shift_nxt;
	logic          q_tick;
	logic          accept;
	logic          slot_rel;
	logic          sioc_nxt;
	logic          oe_nxt;
	logic          out_nxt;

	assign wr.ready = (phase == ph_idle);
	assign accept   = wr.valid && wr.ready;
	assign q_tick   = (q_cnt == qw'(clk_div - 1));

	//////////////////////////////////////////////////
	// Phase, quarter and bit stepping
	//////////////////////////////////////////////////
	always_comb begin
		phase_nxt = phase;
		q_nxt     = q_cnt;
		qtr_nxt   = qtr;
		bit_nxt   = bit_cnt;
		shift_nxt = shift_q;
		if (phase == ph_idle) begin
			if (accept) begin
				phase_nxt = ph_start;
				q_nxt     = '0;
				qtr_nxt   = '0;
				bit_nxt   = '0;
				// Ninth slot of each byte is the don't care bit
				shift_nxt = {sccb_dev_id, 1'b1, wr.reg_addr, 1'b1, wr.reg_data, 1'b1};
			end
		end else if (!q_tick) begin
			q_nxt = q_cnt + 1'b1;
		end else begin
			q_nxt   = '0;
			qtr_nxt = qtr + 1'b1; // Wraps after quarter 3
			case (phase)
				ph_start: begin
					if (qtr == 2'd1) begin
						phase_nxt = ph_bit;
						qtr_nxt   = '0;
					end
				end
				ph_bit: begin
					if (qtr == 2'd3) begin
						if (bit_cnt == 5'd26) begin
							phase_nxt = ph_stop; // All three bytes sent
						end else begin
							bit_nxt   = bit_cnt + 1'b1;
							shift_nxt = {shift_q[25:0], 1'b0};
						end
					end
				end
				ph_stop: begin
					if (qtr == 2'd1) begin
						phase_nxt = ph_idle;
						qtr_nxt   = '0;
					end
				end
				default: phase_nxt = ph_idle;
			endcase
		end
	end

	// Released slots at 8, 17 and 26
	assign slot_rel = (bit_nxt == 5'd8) || (bit_nxt == 5'd17) || (bit_nxt == 5'd26);

	//////////////////////////////////////////////////
	// Line levels, decoded from the next state
	//////////////////////////////////////////////////
	always_comb begin
		sioc_nxt = 1'b1; // Idle bus is high on both lines
		oe_nxt   = 1'b0;
		out_nxt  = 1'b1;
		case (phase_nxt)
			ph_start: begin
				sioc_nxt = (qtr_nxt == 2'd0); // siod falls first, then sioc
				oe_nxt   = 1'b1;
				out_nxt  = 1'b0;
			end
			ph_bit: begin
				sioc_nxt = qtr_nxt[0] ^ qtr_nxt[1]; // High in quarters 1 and 2
				if (!slot_rel) begin
					oe_nxt  = 1'b1;
					out_nxt = shift_nxt[26];
				end
			end
			ph_stop: begin
				sioc_nxt = (qtr_nxt == 2'd1); // siod rises a quarter later
				oe_nxt   = 1'b1;
				out_nxt  = 1'b0;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase    <= ph_idle;
			q_cnt    <= '0;
			qtr      <= '0;
			bit_cnt  <= '0;
			sioc     <= 1'b1;
			siod_out <= 1'b1;
			siod_oe  <= 1'b0;
		end else begin
			phase    <= phase_nxt;
			q_cnt    <= q_nxt;
			qtr      <= qtr_nxt;
			bit_cnt  <= bit_nxt;
			sioc     <= sioc_nxt; // Registered, glitch free on the pads
			siod_out <= out_nxt;
			siod_oe  <= oe_nxt;
		end
	end

	always_ff @(posedge clk) begin
		shift_q <= shift_nxt; // Shifts one slot per bit
	end

endmodule

`default_nettype wire

// File: verilog/camera_config.sv
`timescale 1ns/1ns
`default_nettype none

module camera_config #(
	parameter int clk_div     = 4,
	parameter int num_entries = camera_config_pkg::rom_depth
) (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic start,
	output logic      busy,
	output logic      done,
	output logic      sioc,
	output logic      siod_out, // Only meaningful with siod_oe high
	output logic      siod_oe   // Low releases siod to the pull-up
);
	import camera_config_pkg::*;

	logic [rom_addr_w-1:0] rom_addr;
	logic [7:0]            rom_reg_addr;
	logic [7:0]            rom_reg_data;

	sccb_write_if wr_if ();

	//////////////////////////////////////////////////
	// ROM, sequencer, SCCB writer
	//////////////////////////////////////////////////
	camera_setup_rom camera_setup_rom_i (
		.clk      (clk),
		.rom_addr (rom_addr),
		.reg_addr (rom_reg_addr),
		.reg_data (rom_reg_data)
	);

	config_sequencer #(
		.num_entries (num_entries)
	) config_sequencer_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (start),
		.rom_addr (rom_addr),
		.reg_addr (rom_reg_addr),
		.reg_data (rom_reg_data),
		.wr       (wr_if.source),
		.busy     (busy),
		.done     (done)
	);

	sccb_writer #(
		.clk_div (clk_div)
	) sccb_writer_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.wr       (wr_if.sink),
		.sioc     (sioc),
		.siod_out (siod_out),
		.siod_oe  (siod_oe)
	);

endmodule

`default_nettype wire

// File: verif/sccb_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

// Camera side of the bus, decodes three-phase writes
module sccb_slave_model (
	input  wire logic   clk,
	input  wire logic   arst_n,
	input  wire logic   sioc,
	input  wire logic   siod,         // Resolved line, pull-up applied
	input  wire logic   siod_oe,      // Master drive enable
	output int          write_count,
	output logic [23:0] last_write,   // {device ID, register, value}
	output logic [2:0]  rel_oe,       // Drive enable in the three released slots
	output int          frame_errors
);
	logic        sioc_q;
	logic        siod_q;
	logic        in_frame;
	int          bit_idx;
	logic [26:0] shreg;   // First bit ends up on top
	logic [2:0]  oe_seen;

	//////////////////////////////////////////////////
	// Line sampling, one clk late
	//////////////////////////////////////////////////
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sioc_q       <= 1'b1;
			siod_q       <= 1'b1;
			in_frame     <= 1'b0;
			bit_idx      <= 0;
			shreg        <= '0;
			oe_seen      <= '0;
			write_count  <= 0;
			last_write   <= '0;
			rel_oe       <= '0;
			frame_errors <= 0;
		end else begin
			sioc_q <= sioc;
			siod_q <= siod;
			if (sioc && sioc_q && siod_q && !siod) begin // Start, siod falls with sioc high
				in_frame <= 1'b1;
				bit_idx  <= 0;
				oe_seen  <= '0;
			end else if (sioc && sioc_q && !siod_q && siod) begin // Stop
				in_frame <= 1'b0;
				// 27 bit clocks plus the clock pulse of the stop
				if (!in_frame || bit_idx != 28) begin
					$display("Framing error at %0t ns: stop after %0d clock pulses",
						$time, bit_idx);
					frame_errors <= frame_errors + 1;
				end else begin
					write_count <= write_count + 1;
					last_write  <= {shreg[26:19], shreg[17:10], shreg[8:1]};
					rel_oe      <= oe_seen;
				end
			end else if (sioc && !sioc_q && in_frame) begin
				// Data bit taken on the rising clock
				if (bit_idx < 27) begin
					shreg <= {shreg[25:0], siod};
					case (bit_idx)
						8:  oe_seen[2] <= siod_oe; // After device ID
						17: oe_seen[1] <= siod_oe;
						26: oe_seen[0] <= siod_oe;
						default: begin
						end
					endcase
				end
				bit_idx <= bit_idx + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_camera_config.sv
`timescale 1ns/1ns
`default_nettype none

module tb_camera_config;
	localparam logic [7:0] exp_dev_id   = 8'h42;
	localparam int         table_len    = 30;
	localparam int         run_limit    = 20000; // Cycles, full table at clk_div 4
	localparam int         quiet_cycles = 600;   // Longer than one whole write

	// Register/value pairs in send order
	localparam logic [15:0] setup_table [table_len] = '{
		16'h1204, 16'h1180, 16'h40d0, 16'h1e30, 16'h4fb3, 16'h50b3,
		16'h5100, 16'h523d, 16'h53a7, 16'h54e4, 16'h5640, 16'h589e,
		16'h5988, 16'h5a88, 16'h5b44, 16'h5c67, 16'h5d49, 16'h5e0e,
		16'h6900, 16'h6a40, 16'h6b0a, 16'h6c0a, 16'h6d55, 16'h6e11,
		16'h6f9f, 16'hb084, 16'hb10c, 16'hb20e, 16'hb382, 16'hb40a
	};

	logic clk;
	logic arst_n;
	logic start;
	logic busy;
	logic done;
	logic sioc;
	logic siod_out;
	logic siod_oe;
	wire  siod_line = siod_oe ? siod_out : 1'b1; // Open drain with pull-up

	int          write_count;
	logic [23:0] last_write;
	logic [2:0]  rel_oe;
	int          frame_errors;

	int   test_errs [1:6];
	int   n_checks     = 0;
	int   timeouts     = 0;
	int   total_writes = 0; // Records compared so far
	int   run_base     = 0; // Record count when the current run began
	int   seq_test     = 2; // Test charged with pair checks
	int   done_test    = 3; // Test charged with completion checks
	logic done_q       = 1'b0;

	camera_config #(
		.clk_div (4)
	) camera_config_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (start),
		.busy     (busy),
		.done     (done),
		.sioc     (sioc),
		.siod_out (siod_out),
		.siod_oe  (siod_oe)
	);

	sccb_slave_model bus_monitor_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.sioc         (sioc),
		.siod         (siod_line),
		.siod_oe      (siod_oe),
		.write_count  (write_count),
		.last_write   (last_write),
		.rel_oe       (rel_oe),
		.frame_errors (frame_errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic logic [15:0] expected_pair(input int idx);
		if (idx < 0 || idx >= table_len) begin
			return 16'h1180; // Clock prescaler default
		end
		return setup_table[idx];
	endfunction

	task automatic check_value(input int test, input string name,
		input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			test_errs[test]++;
			$display("MISMATCH at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input int test, input string name);
		if (test_errs[test] == 0) begin
			$display("test %0d %s: ok", test, name);
		end else begin
			$display("test %0d %s: %0d errors", test, name, test_errs[test]);
		end
	endtask

	task automatic note_timeout(input string what);
		$display("Timeout waiting for %s", what);
		timeouts++;
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_writes(input int n, input int limit);
		int cycles;
		cycles = 0;
		while (write_count - run_base < n && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (write_count - run_base < n) note_timeout("bus writes");
	endtask

	task automatic wait_done(input int limit);
		int cycles;
		cycles = 0;
		while (!done && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) note_timeout("done");
	endtask

	//////////////////////////////////////////////////
	// Comparing process, mid-cycle
	//////////////////////////////////////////////////
	always @(negedge clk) begin : compare_writes
		logic [15:0] pair;
		int          idx;
		if (write_count != total_writes) begin
			idx          = total_writes - run_base; // Index within this run
			total_writes = write_count;
			pair         = expected_pair(idx);
			check_value(seq_test, "dev_id", last_write[23:16], exp_dev_id);
			check_value(seq_test, "reg_addr", last_write[15:8], pair[15:8]);
			check_value(seq_test, "reg_data", last_write[7:0], pair[7:0]);
			check_value(6, "siod_oe in released slots", rel_oe, 3'b000);
			if (idx < table_len - 1) check_value(done_test, "busy", busy, 1);
		end
		if (done && !done_q) begin // Stop of the last write already seen
			check_value(done_test, "writes before done", total_writes - run_base, table_len);
			check_value(done_test, "busy with done", busy, 0);
		end
		done_q = done;
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin : stimulus
		int total;
		arst_n = 1'b0;
		start  = 1'b0;
		for (int i = 1; i <= 6; i++) test_errs[i] = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Quiet bus without start
		repeat (100) begin
			@(negedge clk);
			check_value(1, "sioc", sioc, 1);
			check_value(1, "siod", siod_line, 1);
			check_value(1, "busy", busy, 0);
			check_value(1, "done", done, 0);
		end
		check_value(1, "write_count", write_count, 0);
		report_test(1, "idle after reset");

		pulse_start();
		check_value(3, "busy after start", busy, 1);
		wait_writes(10, run_limit);
		pulse_start(); // Mid-transfer, must be dropped
		wait_done(run_limit);
		repeat (quiet_cycles) @(negedge clk);
		check_value(2, "writes in run", write_count - run_base, table_len);
		check_value(2, "frame_errors", frame_errors, 0);
		check_value(4, "writes after second start", write_count - run_base, table_len);
		check_value(4, "done held", done, 1);
		report_test(2, "full sequence");
		report_test(3, "completion");
		report_test(4, "start while busy");

		// Second run from the finished state
		seq_test  = 5;
		done_test = 5;
		run_base  = write_count;
		pulse_start();
		check_value(5, "done cleared", done, 0);
		check_value(5, "busy after restart", busy, 1);
		wait_done(run_limit);
		repeat (quiet_cycles) @(negedge clk);
		check_value(5, "writes in rerun", write_count - run_base, table_len);
		check_value(5, "frame_errors", frame_errors, 0);
		report_test(5, "rerun");
		report_test(6, "released slot");

		total = 0;
		for (int i = 1; i <= 6; i++) total += test_errs[i];
		$display("checks %0d, errors %0d, timeouts %0d", n_checks, total, timeouts);
		if (total == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: camera_config.f
verilog/camera_config_pkg.sv
verilog/sccb_write_if.sv
verilog/camera_setup_rom.sv
verilog/config_sequencer.sv
verilog/sccb_writer.sv
verilog/camera_config.sv
verif/sccb_slave_model.sv
verif/tb_camera_config.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_camera_config
FLIST     := camera_config.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run check clean

all: check

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	grep -q '^test passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
